//--- include/rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// integer register and address width for rv32
`define RV_XLEN 32

// architectural register count, x0 included
`define RV_NUM_REGS 32

// bits needed to name one register
`define RV_REG_IDX_W 5

// fetch advances one word per cycle
`define RV_PC_STEP 32'd4

// address of the first fetch after reset
`define RV_RESET_PC 32'h0000_0000

`endif

//--- hw/rv_isa_pkg.sv
package rv_isa_pkg;

  `include "rv_settings.svh"

  // register value or byte address
  typedef logic [`RV_XLEN-1:0] word_t;

  // raw instruction word
  typedef logic [31:0] insn_t;

  // register index, x0 .. x31
  typedef logic [`RV_REG_IDX_W-1:0] reg_idx_t;

  // encoding fields
  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  // major opcodes, low two bits always 11
  localparam opcode_t op_lui     = 7'b01_101_11;
  localparam opcode_t op_auipc   = 7'b00_101_11;
  localparam opcode_t op_reg_imm = 7'b00_100_11;
  localparam opcode_t op_reg_reg = 7'b01_100_11;
  localparam opcode_t op_system  = 7'b11_100_11;

  // funct3 per alu operation
  // same values for the immediate and register forms
  localparam funct3_t f3_add_sub = 3'b000;
  localparam funct3_t f3_sll     = 3'b001;
  localparam funct3_t f3_slt     = 3'b010;
  localparam funct3_t f3_sltu    = 3'b011;
  localparam funct3_t f3_xor     = 3'b100;
  localparam funct3_t f3_srl_sra = 3'b101;
  localparam funct3_t f3_or      = 3'b110;
  localparam funct3_t f3_and     = 3'b111;

  // funct7 of the plain encodings
  localparam funct7_t f7_base = 7'b000_0000;

  // bit 30 set selects sub / sra
  localparam funct7_t f7_alt  = 7'b010_0000;

endpackage

//--- hw/rv_pipe_pkg.sv
package rv_pipe_pkg;

  // class of the cycle seen in writeback
  // compared against the expected trace
  typedef enum logic [2:0] {
    // never seen once the reset sequence has drained
    cycle_invalid  = 3'd0,
    // bubble left behind by reset
    cycle_reset    = 3'd1,
    // real instruction in writeback
    cycle_no_stall = 3'd2
  } cycle_status_e;

  // operation performed by the execute stage
  typedef enum logic [3:0] {
    // also used for auipc, with pc as operand a
    alu_add    = 4'd0,
    alu_sub    = 4'd1,
    // signed less-than, result 0 or 1
    alu_slt    = 4'd2,
    // unsigned less-than
    alu_sltu   = 4'd3,
    alu_xor    = 4'd4,
    alu_or     = 4'd5,
    alu_and    = 4'd6,
    // shifts use the low 5 bits of b only
    alu_sll    = 4'd7,
    alu_srl    = 4'd8,
    alu_sra    = 4'd9,
    // lui, b is the upper immediate
    alu_pass_b = 4'd10
  } alu_op_e;

endpackage

//--- hw/rv_decoder.sv
`timescale 1ns/1ps

`include "rv_settings.svh"

module rv_decoder
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
(
  input  insn_t    insn,
  output reg_idx_t rs1,
  output reg_idx_t rs2,
  output reg_idx_t rd,
  output word_t    imm,
  output alu_op_e  alu_op,
  output logic     use_imm,
  output logic     use_pc,
  output logic     zero_a,
  output logic     writes_rd,
  output logic     is_ecall
);

  opcode_t opcode;
  funct3_t funct3;
  funct7_t funct7;
  word_t   imm_i;
  word_t   imm_u;
  logic    supported;

  // funct3 to alu op, alt picks sub / sra
  function automatic alu_op_e op_from_funct3(funct3_t f3, logic alt);
    alu_op_e op;
    case (f3)
      f3_add_sub: op = alt ? alu_sub : alu_add;
      f3_sll:     op = alu_sll;
      f3_slt:     op = alu_slt;
      f3_sltu:    op = alu_sltu;
      f3_xor:     op = alu_xor;
      f3_srl_sra: op = alt ? alu_sra : alu_srl;
      f3_or:      op = alu_or;
      default:    op = alu_and;
    endcase
    return op;
  endfunction

  // fixed field positions, same for every format used here
  assign opcode = insn[6:0];
  assign rd     = insn[11:7];
  assign funct3 = insn[14:12];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];
  assign funct7 = insn[31:25];

  // i-type, sign bit is always insn[31]
  assign imm_i = {{(`RV_XLEN-12){insn[31]}}, insn[31:20]};
  // u-type, low 12 bits zero
  assign imm_u = {insn[31:12], 12'b0};

  always_comb begin
    imm       = imm_i;
    alu_op    = alu_add;
    use_imm   = 1'b0;
    use_pc    = 1'b0;
    zero_a    = 1'b0;
    supported = 1'b0;
    is_ecall  = 1'b0;
    case (opcode)
      op_lui: begin
        // a forced to zero so the rs1 field bits never matter
        imm       = imm_u;
        alu_op    = alu_pass_b;
        use_imm   = 1'b1;
        zero_a    = 1'b1;
        supported = 1'b1;
      end
      op_auipc: begin
        imm       = imm_u;
        use_imm   = 1'b1;
        use_pc    = 1'b1;
        supported = 1'b1;
      end
      op_reg_imm: begin
        use_imm = 1'b1;
        // only srai looks at the upper immediate bits
        alu_op  = op_from_funct3(funct3, funct3 == f3_srl_sra && funct7 == f7_alt);
        case (funct3)
          f3_sll:     supported = funct7 == f7_base;
          f3_srl_sra: supported = funct7 == f7_base || funct7 == f7_alt;
          default:    supported = 1'b1;
        endcase
      end
      op_reg_reg: begin
        alu_op    = op_from_funct3(funct3, funct7 == f7_alt);
        // alt encoding legal for sub and sra only, m extension not supported
        supported = funct7 == f7_base ||
                    (funct7 == f7_alt && (funct3 == f3_add_sub || funct3 == f3_srl_sra));
      end
      op_system: begin
        // ecall is all zero above the opcode
        is_ecall = insn[31:7] == '0;
      end
      default: begin
        // anything else retires as a no-op
        supported = 1'b0;
      end
    endcase
  end

  // sole place where x0 writes get dropped
  assign writes_rd = supported && (rd != '0);

endmodule

//--- hw/rv_regfile.sv
`timescale 1ns/1ps

`include "rv_settings.svh"

module rv_regfile (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     we,
  input  logic [`RV_REG_IDX_W-1:0] rd,
  input  logic [`RV_XLEN-1:0]      rd_data,
  input  logic [`RV_REG_IDX_W-1:0] rs1,
  input  logic [`RV_REG_IDX_W-1:0] rs2,
  output logic [`RV_XLEN-1:0]      rs1_data,
  output logic [`RV_XLEN-1:0]      rs2_data
);

  // x1 .. x31, x0 has no storage
  logic [`RV_XLEN-1:0] regs [1:`RV_NUM_REGS-1];

  // async read, same-cycle write is not visible here
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[rd] <= rd_data;
    end
  end

  // decode must have filtered out every x0 write
  a_no_x0_write: assert property (@(posedge clk) disable iff (rst) we |-> rd != '0)
    else $error("register file write to x0");

endmodule

//--- hw/rv_bypass.sv
`timescale 1ns/1ps

`include "rv_settings.svh"

module rv_bypass
  import rv_isa_pkg::*;
(
  input  reg_idx_t d_rs1,
  input  reg_idx_t d_rs2,
  input  reg_idx_t x_rs1,
  input  reg_idx_t x_rs2,
  input  word_t    rf_rs1_data,
  input  word_t    rf_rs2_data,
  input  word_t    x_rs1_data,
  input  word_t    x_rs2_data,
  input  logic     m_we,
  input  reg_idx_t m_rd,
  input  word_t    m_data,
  input  logic     w_we,
  input  reg_idx_t w_rd,
  input  word_t    w_data,
  output word_t    d_rs1_fwd,
  output word_t    d_rs2_fwd,
  output word_t    x_op_a,
  output word_t    x_op_b
);

  // a stage supplies rs only if it really writes it
  // x0 writes are never flagged so x0 can't hit
  function automatic logic hits(logic we, reg_idx_t rd, reg_idx_t rs);
    return we && (rd == rs);
  endfunction

  // wd, writeback value beats the stale rf read
  assign d_rs1_fwd = hits(w_we, w_rd, d_rs1) ? w_data : rf_rs1_data;
  assign d_rs2_fwd = hits(w_we, w_rd, d_rs2) ? w_data : rf_rs2_data;

  // mx before wx, the younger producer wins
  // each operand chosen on its own
  assign x_op_a = hits(m_we, m_rd, x_rs1) ? m_data :
                  hits(w_we, w_rd, x_rs1) ? w_data : x_rs1_data;
  assign x_op_b = hits(m_we, m_rd, x_rs2) ? m_data :
                  hits(w_we, w_rd, x_rs2) ? w_data : x_rs2_data;

endmodule

//--- hw/rv_alu.sv
`timescale 1ns/1ps

`include "rv_settings.svh"

module rv_alu
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
(
  input  alu_op_e alu_op,
  input  word_t   a,
  input  word_t   b,
  output word_t   result
);

  // rv32 shift amount, upper bits of b ignored
  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (alu_op)
      alu_add:    result = a + b;
      alu_sub:    result = a - b;
      // compare results zero-extended to a full word
      alu_slt:    result = word_t'($signed(a) < $signed(b));
      alu_sltu:   result = word_t'(a < b);
      alu_xor:    result = a ^ b;
      alu_or:     result = a | b;
      alu_and:    result = a & b;
      alu_sll:    result = a << shamt;
      alu_srl:    result = a >> shamt;
      // arithmetic, sign bit copied in from the top
      alu_sra:    result = word_t'($signed(a) >>> shamt);
      alu_pass_b: result = b;
      default:    result = '0;
    endcase
  end

  // op code comes from the decoder via the d/x register
  always_comb begin
    if (!$isunknown(alu_op)) begin
      assert (alu_op inside {alu_add, alu_sub, alu_slt, alu_sltu, alu_xor, alu_or,
                             alu_and, alu_sll, alu_srl, alu_sra, alu_pass_b})
        else $error("undefined alu_op %0d", alu_op);
    end
  end

endmodule

//--- hw/rv_pipeline.sv
`timescale 1ns/1ps

`include "rv_settings.svh"

module rv_pipeline
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
(
  input  logic          clk,
  input  logic          rst,
  input  insn_t         insn_from_imem,
  output word_t         pc_to_imem,
  output logic          halt,
  output word_t         trace_writeback_pc,
  output insn_t         trace_writeback_insn,
  output cycle_status_e trace_writeback_cycle_status,
  output logic          trace_writeback_we,
  output reg_idx_t      trace_writeback_rd,
  output word_t         trace_writeback_rd_data
);

  // fetch
  word_t f_pc;

  // decode
  word_t d_pc;
  insn_t d_insn;
  cycle_status_e d_status;
  reg_idx_t d_rs1, d_rs2, d_rd;
  word_t d_imm;
  alu_op_e d_alu_op;
  logic d_use_imm, d_use_pc, d_zero_a, d_writes_rd, d_is_ecall;
  word_t rf_rs1_data, rf_rs2_data;
  word_t d_rs1_fwd, d_rs2_fwd;

  // execute
  word_t x_pc;
  insn_t x_insn;
  cycle_status_e x_status;
  logic x_we, x_is_ecall;
  alu_op_e x_alu_op;
  logic x_use_imm, x_use_pc, x_zero_a;
  reg_idx_t x_rs1, x_rs2, x_rd;
  word_t x_imm, x_rs1_data, x_rs2_data;
  word_t x_op_a, x_op_b, alu_a, alu_b, alu_result;

  // memory, nothing to do but carry the result
  word_t m_pc;
  insn_t m_insn;
  cycle_status_e m_status;
  logic m_we, m_is_ecall;
  reg_idx_t m_rd;
  word_t m_data;

  // writeback
  word_t w_pc;
  insn_t w_insn;
  cycle_status_e w_status;
  logic w_we, w_is_ecall;
  reg_idx_t w_rd;
  word_t w_data;

  // no stalls or redirects, pc just steps
  always_ff @(posedge clk) begin
    if (rst) begin
      f_pc <= `RV_RESET_PC;
    end else begin
      f_pc <= f_pc + `RV_PC_STEP;
    end
  end

  // imem answers in the same cycle
  assign pc_to_imem = f_pc;

  // f/d, insn cleared so decode sees a harmless no-op during reset
  always_ff @(posedge clk) begin
    if (rst) begin
      d_pc     <= '0;
      d_insn   <= '0;
      d_status <= cycle_reset;
    end else begin
      d_pc     <= f_pc;
      d_insn   <= insn_from_imem;
      d_status <= cycle_no_stall;
    end
  end

  rv_decoder u_decoder (
    .insn      (d_insn),
    .rs1       (d_rs1),
    .rs2       (d_rs2),
    .rd        (d_rd),
    .imm       (d_imm),
    .alu_op    (d_alu_op),
    .use_imm   (d_use_imm),
    .use_pc    (d_use_pc),
    .zero_a    (d_zero_a),
    .writes_rd (d_writes_rd),
    .is_ecall  (d_is_ecall)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .we       (w_we),
    .rd       (w_rd),
    .rd_data  (w_data),
    .rs1      (d_rs1),
    .rs2      (d_rs2),
    .rs1_data (rf_rs1_data),
    .rs2_data (rf_rs2_data)
  );

  rv_bypass u_bypass (
    .d_rs1       (d_rs1),
    .d_rs2       (d_rs2),
    .x_rs1       (x_rs1),
    .x_rs2       (x_rs2),
    .rf_rs1_data (rf_rs1_data),
    .rf_rs2_data (rf_rs2_data),
    .x_rs1_data  (x_rs1_data),
    .x_rs2_data  (x_rs2_data),
    .m_we        (m_we),
    .m_rd        (m_rd),
    .m_data      (m_data),
    .w_we        (w_we),
    .w_rd        (w_rd),
    .w_data      (w_data),
    .d_rs1_fwd   (d_rs1_fwd),
    .d_rs2_fwd   (d_rs2_fwd),
    .x_op_a      (x_op_a),
    .x_op_b      (x_op_b)
  );

  // d/x control, only valid slots may write or halt
  always_ff @(posedge clk) begin
    if (rst) begin
      x_pc       <= '0;
      x_insn     <= '0;
      x_status   <= cycle_reset;
      x_we       <= 1'b0;
      x_is_ecall <= 1'b0;
      x_alu_op   <= alu_add;
      x_use_imm  <= 1'b0;
      x_use_pc   <= 1'b0;
      x_zero_a   <= 1'b0;
    end else begin
      x_pc       <= d_pc;
      x_insn     <= d_insn;
      x_status   <= d_status;
      x_we       <= d_writes_rd && (d_status == cycle_no_stall);
      x_is_ecall <= d_is_ecall && (d_status == cycle_no_stall);
      x_alu_op   <= d_alu_op;
      x_use_imm  <= d_use_imm;
      x_use_pc   <= d_use_pc;
      x_zero_a   <= d_zero_a;
    end
  end

  // d/x payload, operands already carry the wd bypass
  always_ff @(posedge clk) begin
    x_rs1      <= d_rs1;
    x_rs2      <= d_rs2;
    x_rd       <= d_rd;
    x_imm      <= d_imm;
    x_rs1_data <= d_rs1_fwd;
    x_rs2_data <= d_rs2_fwd;
  end

  // operand a: zero for lui, pc for auipc, else rs1
  assign alu_a = x_zero_a ? '0 : (x_use_pc ? x_pc : x_op_a);
  assign alu_b = x_use_imm ? x_imm : x_op_b;

  rv_alu u_alu (
    .alu_op (x_alu_op),
    .a      (alu_a),
    .b      (alu_b),
    .result (alu_result)
  );

  // x/m and m/w control
  always_ff @(posedge clk) begin
    if (rst) begin
      m_pc       <= '0;
      m_insn     <= '0;
      m_status   <= cycle_reset;
      m_we       <= 1'b0;
      m_is_ecall <= 1'b0;
      w_pc       <= '0;
      w_insn     <= '0;
      w_status   <= cycle_reset;
      w_we       <= 1'b0;
      w_is_ecall <= 1'b0;
    end else begin
      m_pc       <= x_pc;
      m_insn     <= x_insn;
      m_status   <= x_status;
      m_we       <= x_we;
      m_is_ecall <= x_is_ecall;
      w_pc       <= m_pc;
      w_insn     <= m_insn;
      w_status   <= m_status;
      w_we       <= m_we;
      w_is_ecall <= m_is_ecall;
    end
  end

  // result payload
  always_ff @(posedge clk) begin
    m_rd   <= x_rd;
    m_data <= alu_result;
    w_rd   <= m_rd;
    w_data <= m_data;
  end

  // ecall stops the core when it retires
  assign halt = w_is_ecall && (w_status == cycle_no_stall);

  assign trace_writeback_pc           = w_pc;
  assign trace_writeback_insn         = w_insn;
  assign trace_writeback_cycle_status = w_status;
  assign trace_writeback_we           = w_we;
  assign trace_writeback_rd           = w_rd;
  assign trace_writeback_rd_data      = w_data;

  // every stage register must have been loaded with a real status
  a_status_valid: assert property (@(posedge clk) disable iff (rst)
    trace_writeback_cycle_status != cycle_invalid)
    else $error("cycle_invalid in writeback after reset");

endmodule

//--- dv/rv_pipeline_tb.sv
`timescale 1ns/1ps

`include "rv_settings.svh"

module rv_pipeline_tb
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
();

  localparam int imem_depth = 512;
  // retirements of all tests plus 20 spare cycles per test for reset and pipeline fill
  localparam int total_insns = 12 + 92 + 28 + 200 + 16 + 6;
  localparam int num_tests = 6;
  localparam int cycle_limit = total_insns + 20 * num_tests;
  localparam insn_t nop = 32'h0000_0013;
  localparam insn_t ecall = 32'h0000_0073;

  logic          clk;
  logic          rst;
  insn_t         insn_from_imem;
  word_t         pc_to_imem;
  logic          halt;
  word_t         trace_writeback_pc;
  insn_t         trace_writeback_insn;
  cycle_status_e trace_writeback_cycle_status;
  logic          trace_writeback_we;
  reg_idx_t      trace_writeback_rd;
  word_t         trace_writeback_rd_data;

  insn_t imem [0:imem_depth-1];
  int    prog_len;
  word_t model_regs [0:31];
  logic [31:0] lfsr;
  int    cycle_count;

  rv_pipeline u_dut (
    .clk                          (clk),
    .rst                          (rst),
    .insn_from_imem               (insn_from_imem),
    .pc_to_imem                   (pc_to_imem),
    .halt                         (halt),
    .trace_writeback_pc           (trace_writeback_pc),
    .trace_writeback_insn         (trace_writeback_insn),
    .trace_writeback_cycle_status (trace_writeback_cycle_status),
    .trace_writeback_we           (trace_writeback_we),
    .trace_writeback_rd           (trace_writeback_rd),
    .trace_writeback_rd_data      (trace_writeback_rd_data)
  );

  // 4 ns period
  always #2 clk = ~clk;

  // imem answers the word at the current pc
  always @(posedge clk) begin
    #1;
    insn_from_imem = imem[pc_to_imem[10:2]];
  end

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at first error");
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    assert (cycle_count < cycle_limit)
      else report_failure("timeout, the tests ran past their cycle budget");
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
      else begin
        $display("MISMATCH at %0d ns: %s expected 0x%08h got 0x%08h",
                 $time, name, exp, got);
        report_failure("value mismatch on a DUT output");
      end
  endtask

  // fibonacci lfsr with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit taken
  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // instruction encoders
  function automatic insn_t i_type(input logic [2:0] f3, input logic [4:0] rd,
                                   input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, op_reg_imm};
  endfunction

  function automatic insn_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                   input logic [4:0] rd, input logic [4:0] rs1,
                                   input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, op_reg_reg};
  endfunction

  function automatic insn_t u_type(input opcode_t op, input logic [4:0] rd,
                                   input logic [19:0] imm);
    return {imm, rd, op};
  endfunction

  // rv32i legality of the alu subset
  // anything else retires as a no-op
  function automatic logic is_legal_alu(input insn_t insn);
    logic [6:0] f7;
    logic [2:0] f3;
    f7 = insn[31:25];
    f3 = insn[14:12];
    case (insn[6:0])
      op_lui, op_auipc: return 1'b1;
      op_reg_imm: begin
        // shift immediates carry funct7 in the upper bits
        if (f3 == 3'b001) return f7 == 7'h00;
        if (f3 == 3'b101) return f7 == 7'h00 || f7 == 7'h20;
        return 1'b1;
      end
      op_reg_reg: return f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
      default: return 1'b0;
    endcase
  endfunction

  // architectural result of one legal alu instruction
  function automatic word_t model_result(input insn_t insn, input word_t pc,
                                         input word_t r1, input word_t r2);
    word_t imm_i;
    word_t imm_u;
    word_t b;
    logic [4:0] sh;
    logic alt;
    imm_i = word_t'($signed(insn[31:20]));
    imm_u = {insn[31:12], 12'h000};
    alt = insn[30];
    case (insn[6:0])
      op_lui: return imm_u;
      op_auipc: return pc + imm_u;
      op_reg_imm: b = imm_i;
      default: b = r2;
    endcase
    sh = b[4:0];
    case (insn[14:12])
      // sub only exists in the register form
      3'b000: return (insn[6:0] == op_reg_reg && alt) ? r1 - b : r1 + b;
      3'b001: return r1 << sh;
      3'b010: return ($signed(r1) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011: return (r1 < b) ? 32'd1 : 32'd0;
      3'b100: return r1 ^ b;
      3'b101: return alt ? word_t'($signed(r1) >>> sh) : r1 >> sh;
      3'b110: return r1 | b;
      default: return r1 & b;
    endcase
  endfunction

  // unused words hold addi x0, x0, index
  task automatic load_fill();
    for (int a = 0; a < imem_depth; a++) begin
      imem[a] = i_type(3'b000, 5'd0, 5'd0, 12'(a));
    end
    prog_len = 0;
  endtask

  task automatic emit(input insn_t insn);
    imem[prog_len] = insn;
    prog_len++;
  endtask

  // three no-ops keep every operand out of the bypass paths
  task automatic emit_spaced(input insn_t insn);
    emit(insn);
    repeat (3) emit(nop);
  endtask

  // 5 rising edges with rst high
  // idle outputs checked before release
  task automatic apply_reset();
    @(posedge clk);
    #1 rst = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    check_value("halt", 32'(halt), 32'd0);
    check_value("trace_writeback_we", 32'(trace_writeback_we), 32'd0);
    check_value("trace_writeback_pc", trace_writeback_pc, 32'd0);
    check_value("trace_writeback_insn", trace_writeback_insn, 32'd0);
    check_value("trace_writeback_cycle_status", 32'(trace_writeback_cycle_status),
                32'(cycle_reset));
    @(posedge clk);
    #1 rst = 1'b0;
  endtask

  // counts reset bubbles until the first real retirement
  task automatic wait_first_retire();
    int bubbles;
    bubbles = 0;
    @(posedge clk);
    @(negedge clk);
    while (trace_writeback_cycle_status == cycle_reset) begin
      check_value("halt", 32'(halt), 32'd0);
      check_value("trace_writeback_we", 32'(trace_writeback_we), 32'd0);
      bubbles++;
      assert (bubbles < 10)
        else report_failure("writeback never left the reset status");
      @(negedge clk);
    end
    check_value("reset bubble count", 32'(bubbles), 32'd3);
  endtask

  // reset and check count retirements in program order against the model
  task automatic run_program(input int count);
    insn_t exp_insn;
    word_t exp_pc;
    word_t exp_data;
    logic  exp_we;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    apply_reset();
    wait_first_retire();
    for (int i = 0; i < count; i++) begin
      exp_pc = `RV_RESET_PC + word_t'(i) * `RV_PC_STEP;
      exp_insn = imem[i];
      exp_we = is_legal_alu(exp_insn) && exp_insn[11:7] != 5'd0;
      check_value("trace_writeback_cycle_status", 32'(trace_writeback_cycle_status),
                  32'(cycle_no_stall));
      check_value("trace_writeback_pc", trace_writeback_pc, exp_pc);
      check_value("trace_writeback_insn", trace_writeback_insn, exp_insn);
      // fetch runs four slots ahead of writeback
      check_value("pc_to_imem", pc_to_imem, exp_pc + 4 * `RV_PC_STEP);
      check_value("halt", 32'(halt), 32'(exp_insn == ecall));
      check_value("trace_writeback_we", 32'(trace_writeback_we), 32'(exp_we));
      if (exp_we) begin
        exp_data = model_result(exp_insn, exp_pc, model_regs[exp_insn[19:15]],
                                model_regs[exp_insn[24:20]]);
        check_value("trace_writeback_rd", 32'(trace_writeback_rd), 32'(exp_insn[11:7]));
        check_value("trace_writeback_rd_data", trace_writeback_rd_data, exp_data);
        model_regs[exp_insn[11:7]] = exp_data;
      end
      @(negedge clk);
    end
  endtask

  // fill words only so we and halt stay low
  task automatic reset_and_trace();
    load_fill();
    run_program(12);
  endtask

  // every operation on its own
  task automatic each_alu_op();
    load_fill();
    emit_spaced(i_type(f3_add_sub, 5'd1, 5'd0, 12'h123));
    emit_spaced(i_type(f3_add_sub, 5'd2, 5'd0, 12'hfff));
    emit_spaced(u_type(op_lui, 5'd3, 20'h80000));
    emit_spaced(u_type(op_auipc, 5'd4, 20'h12345));
    emit_spaced(r_type(f7_base, f3_add_sub, 5'd5, 5'd1, 5'd2));
    emit_spaced(r_type(f7_alt, f3_add_sub, 5'd6, 5'd1, 5'd2));
    emit_spaced(r_type(f7_base, f3_slt, 5'd7, 5'd2, 5'd1));
    emit_spaced(r_type(f7_base, f3_sltu, 5'd8, 5'd2, 5'd1));
    emit_spaced(r_type(f7_base, f3_xor, 5'd9, 5'd1, 5'd2));
    emit_spaced(r_type(f7_base, f3_or, 5'd10, 5'd1, 5'd3));
    emit_spaced(r_type(f7_base, f3_and, 5'd11, 5'd1, 5'd2));
    // 36 has bits above the 5-bit shift amount
    emit_spaced(i_type(f3_add_sub, 5'd20, 5'd0, 12'd36));
    emit_spaced(r_type(f7_base, f3_sll, 5'd12, 5'd1, 5'd20));
    emit_spaced(r_type(f7_base, f3_srl_sra, 5'd13, 5'd3, 5'd20));
    emit_spaced(r_type(f7_alt, f3_srl_sra, 5'd14, 5'd3, 5'd20));
    emit_spaced(i_type(f3_slt, 5'd15, 5'd2, 12'd1));
    emit_spaced(i_type(f3_sltu, 5'd16, 5'd1, 12'hfff));
    emit_spaced(i_type(f3_xor, 5'd17, 5'd1, 12'hf00));
    emit_spaced(i_type(f3_or, 5'd18, 5'd1, 12'h700));
    emit_spaced(i_type(f3_and, 5'd19, 5'd2, 12'h0f0));
    emit_spaced(i_type(f3_sll, 5'd21, 5'd1, 12'd31));
    emit_spaced(i_type(f3_srl_sra, 5'd22, 5'd3, 12'd3));
    emit_spaced(i_type(f3_srl_sra, 5'd23, 5'd3, {7'h20, 5'd3}));
    run_program(prog_len);
  endtask

  // consumers at distance 1, 2 and 3 hit mx, wx and wd
  task automatic forwarding_pairs();
    load_fill();
    emit(i_type(f3_add_sub, 5'd1, 5'd0, 12'd100));
    emit(i_type(f3_add_sub, 5'd2, 5'd0, 12'hffd));
    repeat (3) emit(nop);
    // rs1 from each stage
    emit(i_type(f3_add_sub, 5'd3, 5'd1, 12'd7));
    emit(r_type(f7_base, f3_add_sub, 5'd4, 5'd3, 5'd2));
    emit(r_type(f7_base, f3_add_sub, 5'd5, 5'd3, 5'd2));
    emit(r_type(f7_base, f3_add_sub, 5'd6, 5'd3, 5'd2));
    // rs2 from each stage
    emit(i_type(f3_add_sub, 5'd3, 5'd2, 12'd11));
    emit(r_type(f7_alt, f3_add_sub, 5'd4, 5'd1, 5'd3));
    emit(r_type(f7_alt, f3_add_sub, 5'd5, 5'd1, 5'd3));
    emit(r_type(f7_alt, f3_add_sub, 5'd6, 5'd1, 5'd3));
    // rs1 via mx and rs2 via wx
    emit(i_type(f3_add_sub, 5'd7, 5'd0, 12'd9));
    emit(i_type(f3_add_sub, 5'd8, 5'd0, 12'hfec));
    emit(r_type(f7_base, f3_or, 5'd9, 5'd8, 5'd7));
    // rs1 via wd and rs2 via wx
    emit(i_type(f3_add_sub, 5'd7, 5'd1, 12'd1));
    emit(i_type(f3_add_sub, 5'd8, 5'd2, 12'd2));
    emit(nop);
    emit(r_type(f7_base, f3_slt, 5'd9, 5'd7, 5'd8));
    // both operands from one producer and then chains
    emit(i_type(f3_add_sub, 5'd10, 5'd0, 12'd55));
    emit(r_type(f7_base, f3_add_sub, 5'd11, 5'd10, 5'd10));
    emit(r_type(f7_base, f3_add_sub, 5'd12, 5'd11, 5'd10));
    emit(r_type(f7_alt, f3_add_sub, 5'd12, 5'd12, 5'd11));
    emit(r_type(f7_alt, f3_srl_sra, 5'd13, 5'd2, 5'd12));
    // younger write to x15 must beat the older one
    emit(i_type(f3_add_sub, 5'd15, 5'd0, 12'd1));
    emit(i_type(f3_add_sub, 5'd15, 5'd0, 12'd2));
    emit(r_type(f7_base, f3_add_sub, 5'd16, 5'd15, 5'd15));
    run_program(prog_len);
  endtask

  // registers limited to x0..x7 so most operands hit a bypass
  task automatic random_alu_program();
    logic [31:0] kind;
    logic [31:0] rd;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [31:0] f3;
    logic [31:0] alt;
    logic [31:0] imm;
    logic [6:0]  f7;
    load_fill();
    for (int n = 0; n < 200; n++) begin
      rand_bits(3, kind);
      rand_bits(3, rd);
      rand_bits(3, rs1);
      rand_bits(3, rs2);
      rand_bits(3, f3);
      rand_bits(1, alt);
      if (kind < 4) begin
        f7 = (alt[0] && (f3[2:0] == 3'b000 || f3[2:0] == 3'b101)) ? 7'h20 : 7'h00;
        emit(r_type(f7, f3[2:0], rd[4:0], rs1[4:0], rs2[4:0]));
      end else if (kind < 7) begin
        rand_bits(12, imm);
        // keep shift immediates legal
        if (f3[2:0] == 3'b001) begin
          imm = {20'd0, 7'h00, imm[4:0]};
        end else if (f3[2:0] == 3'b101) begin
          imm = {20'd0, (alt[0] ? 7'h20 : 7'h00), imm[4:0]};
        end
        emit(i_type(f3[2:0], rd[4:0], rs1[4:0], imm[11:0]));
      end else begin
        rand_bits(20, imm);
        emit(u_type(alt[0] ? op_lui : op_auipc, rd[4:0], imm[19:0]));
      end
    end
    run_program(prog_len);
  endtask

  // nothing may reach x0 or any register from an unsupported word
  task automatic x0_and_unsupported();
    load_fill();
    emit(i_type(f3_add_sub, 5'd1, 5'd0, 12'd77));
    emit(i_type(f3_add_sub, 5'd0, 5'd1, 12'd5));
    emit(r_type(f7_base, f3_add_sub, 5'd2, 5'd0, 5'd1));
    emit(u_type(op_lui, 5'd0, 20'habcde));
    emit(nop);
    emit(r_type(f7_base, f3_or, 5'd3, 5'd0, 5'd0));
    // mul from the absent m extension
    emit(r_type(7'h01, 3'b000, 5'd1, 5'd1, 5'd1));
    emit(r_type(f7_base, f3_add_sub, 5'd4, 5'd1, 5'd0));
    emit(32'h0000_0000);
    emit(32'hffff_ffff);
    // lw x1, 0(x1)
    emit({12'd0, 5'd1, 3'b010, 5'd1, 7'b000_0011});
    // ebreak
    emit(32'h0010_0073);
    // slli with a bad funct7
    emit(i_type(f3_sll, 5'd1, 5'd1, {7'h20, 5'd1}));
    // fence
    emit(32'h0ff0_000f);
    emit(r_type(f7_base, f3_add_sub, 5'd5, 5'd1, 5'd2));
    emit(r_type(f7_alt, f3_add_sub, 5'd6, 5'd0, 5'd1));
    run_program(prog_len);
  endtask

  // halt only while an ecall sits in writeback
  task automatic ecall_halt();
    load_fill();
    emit(i_type(f3_add_sub, 5'd1, 5'd0, 12'd3));
    emit(ecall);
    emit(i_type(f3_add_sub, 5'd2, 5'd1, 12'd4));
    emit(ecall);
    emit(32'h0010_0073);
    emit(i_type(f3_add_sub, 5'd3, 5'd2, 12'd1));
    run_program(prog_len);
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    insn_from_imem = '0;
    lfsr = 32'd88050;
    cycle_count = 0;
    prog_len = 0;
    reset_and_trace();
    each_alu_op();
    forwarding_pairs();
    random_alu_program();
    x0_and_unsupported();
    ecall_halt();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

//--- flist.f
+incdir+include
hw/rv_isa_pkg.sv
hw/rv_pipe_pkg.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_bypass.sv
hw/rv_alu.sv
hw/rv_pipeline.sv
dv/rv_pipeline_tb.sv

//--- Makefile
# Verilator build and run of the rv32i pipeline testbench

TOP       ?= rv_pipeline_tb
FLIST     ?= flist.f
VERILATOR ?= verilator
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

PASS_TEXT := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "variables: TOP FLIST VERILATOR BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FLIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)
